// ==== fetch_unit.f ====
common/fetch_pkg.sv
common/mem_pkg.sv
icache/refill_counter.sv
icache/icache.sv
src/fetch_control.sv
src/fetch_unit.sv
tests/mem_model.sv
tests/fetch_unit_tb.sv

// ==== Bender.yml ====
package:
  name: fetch_unit

sources:
  - files:
      - common/fetch_pkg.sv
      - common/mem_pkg.sv
      - icache/refill_counter.sv
      - icache/icache.sv
      - src/fetch_control.sv
      - src/fetch_unit.sv
  - target: test
    files:
      - tests/mem_model.sv
      - tests/fetch_unit_tb.sv

// ==== tests/fetch_unit_tb.sv ====
`timescale 1ns/1ps

module fetch_unit_tb;
  import fetch_pkg::*;
  import mem_pkg::*;

  localparam logic [31:0] reset_pc = 32'h8000_0000;
  localparam int line_words = 4;
  localparam int num_lines = 16;
  localparam int mem_words = 256;
  localparam int period = 40;
  localparam int drive_delay = 2;
  localparam logic [31:0] line_mask = ~32'(line_words * 4 - 1);

  // one refill of a line costs at most line_words beats of about eight cycles each.
  localparam int planned_transfers = 240;
  localparam int miss_cycles = line_words * 8 + 6;
  localparam int timeout_ns = (planned_transfers * miss_cycles + 500) * period;

  // word indices of the code regions.
  localparam int region_b = 64;
  localparam int region_c = 100;

  logic        clock;
  logic        reset;
  logic        flush;
  logic [31:0] redirect_pc;
  logic        fencei;
  logic        out_valid;
  logic        out_ready;
  fetch_out_t  out;
  logic        mem_req_valid;
  mem_req_t    mem_req;
  logic        mem_ack;
  mem_resp_t   mem_resp;
  logic [1:0]  ack_delay;
  logic        mem_error;

  logic [31:0] image [mem_words];
  logic [31:0] rng;
  logic        random_ready;
  logic [31:0] expected_pc;
  int          accepted;
  logic        req_seen;
  int          beats_left;
  logic [31:0] last_req_addr;
  logic        fence_sent;
  int          fence_refills;
  int          error_count;

  fetch_unit #(
    .reset_pc(reset_pc),
    .line_words(line_words),
    .num_lines(num_lines)
  ) dut0 (
    .clock(clock),
    .reset(reset),
    .flush(flush),
    .redirect_pc(redirect_pc),
    .fencei(fencei),
    .out_valid(out_valid),
    .out_ready(out_ready),
    .out(out),
    .mem_req_valid(mem_req_valid),
    .mem_req(mem_req),
    .mem_ack(mem_ack),
    .mem_resp(mem_resp)
  );

  mem_model #(
    .base_addr(reset_pc),
    .depth(mem_words)
  ) mem0 (
    .clock(clock),
    .reset(reset),
    .ack_delay(ack_delay),
    .req_valid(mem_req_valid),
    .req(mem_req),
    .ack(mem_ack),
    .resp(mem_resp),
    .error(mem_error)
  );

  always begin
    #(period / 2) clock = ~clock;
  end

  // ************************************************************
  // helpers and reference model
  // ************************************************************

  function automatic logic [31:0] lcg(input logic [31:0] state);
    lcg = state * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [31:0] word_addr(input int index);
    word_addr = reset_pc + 32'(index * 4);
  endfunction

  function automatic int word_index(input logic [31:0] pc);
    word_index = int'((pc - reset_pc) >> 2);
  endfunction

  // an addi whose immediate folds all address bits, so no two nearby words match.
  function automatic logic [31:0] fill_word(input logic [31:0] addr);
    logic [11:0] imm;
    imm = addr[13:2] ^ addr[25:14] ^ {6'd0, addr[31:26]};
    fill_word = {imm, 5'd1, 3'b000, 5'd1, 7'h13};
  endfunction

  function automatic logic [31:0] branch_word(input int from_word, input int to_word);
    logic [12:0] off;
    off = 13'((to_word - from_word) * 4);
    branch_word = {off[12], off[10:5], 5'd2, 5'd1, 3'b000, off[4:1], off[11], 7'b1100011};
  endfunction

  // backward conditional branches go to their target, everything else to pc + 4.
  function automatic logic [31:0] next_pc(input logic [31:0] pc, input logic [31:0] inst);
    logic signed [12:0] off;
    off = {inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    if ((inst[6:2] == opcode_branch) && (off < 0)) begin
      next_pc = pc + 32'(off);
    end else begin
      next_pc = pc + 32'd4;
    end
  endfunction

  task automatic report_failure();
    error_count++;
    $display("Test failures found");
    $fatal(1, "stopping at the first failure");
  endtask

  task automatic check_fetch(input fetch_out_t got, input fetch_out_t exp);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t ns: fetch gave pc %h inst %h, expected pc %h inst %h",
               $time, got.pc, got.inst, exp.pc, exp.inst);
      report_failure();
    end
  endtask

  task automatic check_req(input mem_req_t got, input mem_req_t exp);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t ns: refill beat address %h, expected %h",
               $time, got.addr, exp.addr);
      report_failure();
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t ns: %s is %b, expected %b", $time, what, got, exp);
      report_failure();
    end
  endtask

  task automatic put_word(input int index, input logic [31:0] word);
    image[index] = word;
    mem0.words[index] = word;
  endtask

  task automatic load_program();
    for (int i = 0; i < mem_words; i++) begin
      put_word(i, fill_word(word_addr(i)));
    end
    // straight code with two forward branches, then a loop from word 40 back to 20.
    put_word(6, branch_word(6, 9));
    put_word(13, branch_word(13, 15));
    put_word(40, branch_word(40, 20));
    put_word(75, branch_word(75, 68));
    put_word(103, branch_word(103, 105));
    put_word(107, branch_word(107, 100));
  endtask

  task automatic rewrite_region_c();
    @(negedge clock);
    for (int i = region_c; i < region_c + 7; i++) begin
      if (i != 103) begin
        put_word(i, fill_word(word_addr(i)) ^ 32'hfff0_0000);
      end
    end
  endtask

  task automatic at_drive_point();
    @(posedge clock);
    #drive_delay;
  endtask

  task automatic wait_transfers(input int count);
    int target;
    target = accepted + count;
    while (accepted < target) begin
      @(posedge clock);
    end
    #drive_delay;
  endtask

  // starts at a drive point and holds flush for one cycle.
  task automatic redirect_to(input logic [31:0] pc);
    flush = 1'b1;
    redirect_pc = pc;
    at_drive_point();
    flush = 1'b0;
  endtask

  // ************************************************************
  // checkers
  // ************************************************************

  always @(posedge clock) begin
    #drive_delay;
    rng = lcg(rng);
    ack_delay = rng[25:24];
    out_ready = random_ready ? rng[28] : 1'b1;
  end

  always @(negedge clock) begin : compare_fetch
    fetch_out_t expected;
    if (reset) begin
      expected_pc = reset_pc;
    end else if (flush) begin
      check_flag(out_valid, 1'b0, "out_valid during a flush");
      expected_pc = redirect_pc;
    end else if (out_valid && out_ready) begin
      expected.pc = expected_pc;
      expected.inst = image[word_index(expected_pc)];
      check_fetch(out, expected);
      expected_pc = next_pc(expected_pc, expected.inst);
      accepted++;
    end
  end

  always @(negedge clock) begin : monitor_refill
    mem_req_t expected;
    if (reset) begin
      req_seen = 1'b0;
      beats_left = 0;
    end else begin
      if (mem_req_valid && !req_seen) begin
        if (beats_left == 0) begin
          expected.addr = mem_req.addr & line_mask;
          beats_left = line_words;
        end else begin
          expected.addr = last_req_addr + 32'd4;
        end
        check_req(mem_req, expected);
        last_req_addr = mem_req.addr;
        beats_left--;
        if (fence_sent && (mem_req.addr >= word_addr(region_c)) &&
            (mem_req.addr < word_addr(region_c + 8))) begin
          fence_refills++;
        end
      end
      req_seen = mem_req_valid;
    end
  end

  always @(posedge mem_error) begin
    report_failure();
  end

  initial begin : watchdog
    #(timeout_ns);
    $display("the fetch unit appears to hang: run still going after %0d ns with %0d transfers",
             timeout_ns, accepted);
    report_failure();
  end

  initial begin
    clock = 1'b0;
    reset = 1'b1;
    flush = 1'b0;
    redirect_pc = reset_pc;
    fencei = 1'b0;
    out_ready = 1'b1;
    ack_delay = 2'd0;
    rng = 32'd12709;
    random_ready = 1'b0;
    fence_sent = 1'b0;
    fence_refills = 0;
    error_count = 0;
    accepted = 0;
    load_program();
    repeat (5) @(posedge clock);
    #drive_delay;
    reset = 1'b0;

    wait_transfers(60);
    @(negedge clock);
    random_ready = 1'b1;
    wait_transfers(60);

    // the loop in region a is cached, so this flush lands on a hit.
    redirect_to(word_addr(region_c));
    wait_transfers(40);

    // the second flush arrives while the first target is still refilling.
    redirect_to(word_addr(region_b));
    while (!mem_req_valid) begin
      at_drive_point();
    end
    redirect_to(word_addr(68));
    wait_transfers(40);

    rewrite_region_c();
    at_drive_point();
    fencei = 1'b1;
    fence_sent = 1'b1;
    redirect_to(word_addr(region_c));
    fencei = 1'b0;
    wait_transfers(40);
    check_flag(fence_refills > 0, 1'b1, "refill of rewritten lines after fence.i");

    if (error_count == 0) begin
      $display("All tests passed!");
      $finish;
    end else begin
      report_failure();
    end
  end

endmodule

// ==== tests/mem_model.sv ====
`timescale 1ns/1ps

module mem_model #(
  parameter logic [31:0] base_addr = 32'h8000_0000,
  parameter int          depth     = 256
) (
  input  logic               clock,
  input  logic               reset,
  input  logic [1:0]         ack_delay,
  input  logic               req_valid,
  input  mem_pkg::mem_req_t  req,
  output logic               ack,
  output mem_pkg::mem_resp_t resp,
  output logic               error
);
  import mem_pkg::*;

  logic [31:0] words [depth];
  logic        valid_seen;
  mem_req_t    req_seen;
  int          waited;
  logic [31:0] offset;

  task automatic protocol_error(input string what);
    $display("memory model error at %0t ns: %s", $time, what);
    error = 1'b1;
  endtask

  // the port is sampled and driven just after each rising edge.
  initial begin
    ack = 1'b0;
    resp = '0;
    error = 1'b0;
    valid_seen = 1'b0;
    req_seen = '0;
    waited = 0;
    forever begin
      @(posedge clock);
      #1;
      if (reset) begin
        ack = 1'b0;
        waited = 0;
        valid_seen = 1'b0;
      end else begin
        if (req_valid && !valid_seen && ack) begin
          protocol_error("a new request was raised while the previous ack was still high");
        end
        if (!req_valid && valid_seen && !ack) begin
          protocol_error("the request was withdrawn before it was acknowledged");
        end
        if (req_valid && valid_seen && (req != req_seen)) begin
          protocol_error("the request address changed while the request was pending");
        end
        if (req_valid && !ack) begin
          if (waited < int'(ack_delay)) begin
            waited++;
          end else begin
            offset = req.addr - base_addr;
            if ((offset[1:0] != 2'b00) || (offset >= 32'(depth * 4))) begin
              protocol_error("the request address is outside the memory or not word aligned");
            end
            resp.data = words[offset >> 2];
            ack = 1'b1;
            waited = 0;
          end
        end else if (!req_valid && ack) begin
          ack = 1'b0;
        end
        valid_seen = req_valid;
        req_seen = req;
      end
    end
  end

endmodule

// ==== src/fetch_unit.sv ====
`timescale 1ns/1ps

module fetch_unit #(
  parameter logic [fetch_pkg::xlen-1:0] reset_pc = 32'h8000_0000,
  parameter int line_words = 4,
  parameter int num_lines  = 16
) (
  input  logic                       clock,
  input  logic                       reset,
  input  logic                       flush,
  input  logic [fetch_pkg::xlen-1:0] redirect_pc,
  input  logic                       fencei,
  output logic                       out_valid,
  input  logic                       out_ready,
  output fetch_pkg::fetch_out_t      out,
  output logic                       mem_req_valid,
  output mem_pkg::mem_req_t          mem_req,
  input  logic                       mem_ack,
  input  mem_pkg::mem_resp_t         mem_resp
);
  import fetch_pkg::*;

  logic [xlen-1:0] fetch_pc;
  logic            hit;
  logic [xlen-1:0] cache_inst;

  fetch_control #(
    .reset_pc(reset_pc)
  ) control (
    .clock(clock),
    .reset(reset),
    .flush(flush),
    .redirect_pc(redirect_pc),
    .hit(hit),
    .cache_inst(cache_inst),
    .fetch_pc(fetch_pc),
    .out_ready(out_ready),
    .out_valid(out_valid),
    .out(out)
  );

  // the cache refills on its own whenever fetch_pc misses.
  icache #(
    .line_words(line_words),
    .num_lines(num_lines)
  ) cache (
    .clock(clock),
    .reset(reset),
    .fencei(fencei),
    .addr(fetch_pc),
    .hit(hit),
    .inst(cache_inst),
    .mem_req_valid(mem_req_valid),
    .mem_req(mem_req),
    .mem_ack(mem_ack),
    .mem_resp(mem_resp)
  );

endmodule

// ==== src/fetch_control.sv ====
`timescale 1ns/1ps

module fetch_control #(
  parameter logic [fetch_pkg::xlen-1:0] reset_pc = 32'h8000_0000
) (
  input  logic                         clock,
  input  logic                         reset,
  input  logic                         flush,
  input  logic [fetch_pkg::xlen-1:0]   redirect_pc,
  input  logic                         hit,
  input  logic [fetch_pkg::xlen-1:0]   cache_inst,
  output logic [fetch_pkg::xlen-1:0]   fetch_pc,
  input  logic                         out_ready,
  output logic                         out_valid,
  output fetch_pkg::fetch_out_t        out
);
  import fetch_pkg::*;

  typedef enum logic {
    st_wait = 1'b0,
    st_hold = 1'b1
  } state_t;

  state_t          state;
  state_t          state_next;
  logic            out_valid_r;
  logic            out_valid_r_next;
  logic            flush_r;
  logic            flush_r_next;
  logic [xlen-1:0] fetch_pc_next;
  logic            load_out;
  logic            slot_free;
  logic [xlen-1:0] imm_b;
  logic            predict_taken;
  logic [xlen-1:0] pc_pred;

  // ************************************************************
  // static prediction
  // ************************************************************

  assign imm_b = {{(xlen-12){cache_inst[31]}}, cache_inst[7], cache_inst[30:25],
                  cache_inst[11:8], 1'b0};

  // backward conditional branches are taken, everything else falls through.
  assign predict_taken = (cache_inst[6:2] == opcode_branch) && cache_inst[31];
  assign pc_pred = fetch_pc + (predict_taken ? imm_b : inst_bytes);

  // ************************************************************
  // wait/hold machine
  // ************************************************************

  assign slot_free = !out_valid_r || out_ready;

  always_comb begin
    state_next = state;
    out_valid_r_next = out_valid_r;
    flush_r_next = flush_r;
    fetch_pc_next = fetch_pc;
    load_out = 1'b0;
    case (state)
      st_wait: begin
        if (hit) begin
          if (flush || flush_r) begin
            // the word at the old pc is dropped and fetch restarts at the target.
            flush_r_next = 1'b0;
            out_valid_r_next = 1'b0;
            fetch_pc_next = redirect_pc;
          end else if (slot_free) begin
            out_valid_r_next = 1'b1;
            load_out = 1'b1;
            fetch_pc_next = pc_pred;
          end else begin
            state_next = st_hold;
          end
        end else begin
          if (flush) begin
            flush_r_next = 1'b1;
          end
          if (out_ready || flush) begin
            out_valid_r_next = 1'b0;
          end
        end
      end
      st_hold: begin
        if (flush) begin
          state_next = st_wait;
          out_valid_r_next = 1'b0;
          fetch_pc_next = redirect_pc;
        end else if (slot_free) begin
          state_next = st_wait;
          out_valid_r_next = 1'b1;
          load_out = 1'b1;
          fetch_pc_next = pc_pred;
        end
      end
      default: begin
        state_next = st_wait;
      end
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= st_wait;
      out_valid_r <= 1'b0;
      flush_r <= 1'b0;
      fetch_pc <= reset_pc;
    end else begin
      state <= state_next;
      out_valid_r <= out_valid_r_next;
      flush_r <= flush_r_next;
      fetch_pc <= fetch_pc_next;
    end
  end

  always_ff @(posedge clock) begin
    if (load_out) begin
      out.pc <= fetch_pc;
      out.inst <= cache_inst;
    end
  end

  // a flush kills the slot in the same cycle so decode never takes a wrong-path word.
  assign out_valid = out_valid_r && !flush;

  // a stalled instruction stays put until it is taken or flushed.
  assert property (@(posedge clock) disable iff (reset)
    out_valid && !out_ready |=> $stable(out) && (out_valid || flush));

  assert property (@(posedge clock) disable iff (reset) fetch_pc[1:0] == 2'b00);

endmodule

// ==== icache/icache.sv ====
`timescale 1ns/1ps

module icache #(
  parameter int line_words = 4,
  parameter int num_lines  = 16
) (
  input  logic                       clock,
  input  logic                       reset,
  input  logic                       fencei,
  input  logic [fetch_pkg::xlen-1:0] addr,
  output logic                       hit,
  output logic [fetch_pkg::xlen-1:0] inst,
  output logic                       mem_req_valid,
  output mem_pkg::mem_req_t          mem_req,
  input  logic                       mem_ack,
  input  mem_pkg::mem_resp_t         mem_resp
);
  import fetch_pkg::*;

  localparam int offset_bits = $clog2(line_words);
  localparam int index_bits  = $clog2(num_lines);
  localparam int tag_bits    = xlen - index_bits - offset_bits - 2;

  typedef enum logic [1:0] {
    st_idle,
    st_req,
    st_release
  } refill_state_t;

  logic [tag_bits-1:0]    addr_tag;
  logic [index_bits-1:0]  addr_index;
  logic [offset_bits-1:0] addr_offset;

  logic [num_lines-1:0] valid;
  logic [tag_bits-1:0]  tags [num_lines];
  logic [xlen-1:0]      data [num_lines][line_words];

  refill_state_t          state;
  logic [tag_bits-1:0]    refill_tag;
  logic [index_bits-1:0]  refill_index;
  logic                   start;
  logic                   step;
  logic [offset_bits-1:0] beat;
  logic                   last;

  // ************************************************************
  // lookup
  // ************************************************************

  assign addr_tag = addr[xlen-1 -: tag_bits];
  assign addr_index = addr[2+offset_bits +: index_bits];
  assign addr_offset = addr[2 +: offset_bits];

  assign hit = valid[addr_index] && (tags[addr_index] == addr_tag);
  assign inst = data[addr_index][addr_offset];

  // ************************************************************
  // refill
  // ************************************************************

  // a new line is only requested once the memory has dropped its last ack.
  assign start = (state == st_idle) && !hit && !mem_ack;
  assign step = (state == st_release) && !mem_ack;

  refill_counter #(
    .line_words(line_words)
  ) counter (
    .clock(clock),
    .reset(reset),
    .start(start),
    .step(step),
    .beat(beat),
    .last(last),
    .busy()
  );

  assign mem_req.addr = {refill_tag, refill_index, beat, 2'b00};

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= st_idle;
      mem_req_valid <= 1'b0;
      valid <= '0;
    end else begin
      if (fencei) begin
        valid <= '0;
      end
      case (state)
        st_idle: begin
          if (start) begin
            valid[addr_index] <= 1'b0;
            mem_req_valid <= 1'b1;
            state <= st_req;
          end
        end
        st_req: begin
          if (mem_ack) begin
            mem_req_valid <= 1'b0;
            state <= st_release;
          end
        end
        st_release: begin
          if (step) begin
            if (last) begin
              // written after the fence.i clear so an ongoing refill still lands.
              valid[refill_index] <= 1'b1;
              state <= st_idle;
            end else begin
              mem_req_valid <= 1'b1;
              state <= st_req;
            end
          end
        end
        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (start) begin
      refill_tag <= addr_tag;
      refill_index <= addr_index;
    end
    if ((state == st_req) && mem_ack) begin
      data[refill_index][beat] <= mem_resp.data;
    end
    if (step && last) begin
      tags[refill_index] <= refill_tag;
    end
  end

  assert property (@(posedge clock) disable iff (reset)
    $rose(mem_req_valid) |-> $past(!mem_ack));

  assert property (@(posedge clock) disable iff (reset)
    mem_req_valid && $past(mem_req_valid) |-> $stable(mem_req));

endmodule

// ==== icache/refill_counter.sv ====
`timescale 1ns/1ps

module refill_counter #(
  parameter int line_words = 4,
  localparam int beat_bits = $clog2(line_words)
) (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 start,
  input  logic                 step,
  output logic [beat_bits-1:0] beat,
  output logic                 last,
  output logic                 busy
);

  // the final beat is the one at the top word of the line.
  assign last = busy && (beat == beat_bits'(line_words - 1));

  always_ff @(posedge clock) begin
    if (reset) begin
      busy <= 1'b0;
      beat <= '0;
    end else if (start) begin
      busy <= 1'b1;
      beat <= '0;
    end else if (step && busy) begin
      if (last) begin
        busy <= 1'b0;
      end
      // line_words is a power of two so the count wraps to zero after the last beat.
      beat <= beat + 1'b1;
    end
  end

endmodule

// ==== common/mem_pkg.sv ====
package mem_pkg;

  localparam int addr_bits = 32;
  localparam int data_bits = 32;

  // one refill beat asks for a single word aligned address.
  typedef struct packed {
    logic [addr_bits-1:0] addr;
  } mem_req_t;

  // read data returned with the ack of a beat.
  typedef struct packed {
    logic [data_bits-1:0] data;
  } mem_resp_t;

endpackage

// ==== common/fetch_pkg.sv ====
package fetch_pkg;

  // ************************************************************
  // widths and constants
  // ************************************************************

  localparam int xlen = 32;

  // every instruction is four bytes since compressed encodings are not supported.
  localparam logic [xlen-1:0] inst_bytes = 32'd4;

  // the major opcode is inst[6:2].
  localparam int opcode_bits = 5;

  // conditional branches (beq, bne, blt, bge, bltu, bgeu).
  localparam logic [opcode_bits-1:0] opcode_branch = 5'b11000;

  // ************************************************************
  // decode channel
  // ************************************************************

  // one fetched instruction together with the address it came from.
  typedef struct packed {
    logic [xlen-1:0] pc;
    logic [xlen-1:0] inst;
  } fetch_out_t;

endpackage
